// ==== hdl/fp_add_pkg.sv ====
package fp_add_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Single precision field widths
	localparam int EXP_WIDTH = 8;
	localparam int MAN_WIDTH = 23;
	localparam int FP_WIDTH = 32;

	// Carry, hidden bit, fraction, three guard bits
	localparam int EXT_WIDTH = MAN_WIDTH + 5;

	// Exponent encoding
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX = 255;

	// Canonical quiet NaN
	localparam logic [FP_WIDTH-1:0] QNAN_WORD = 32'h7fc00000;

	////////////////////////////////////////////////////////////////////////////
	// Word and field types
	typedef logic [FP_WIDTH-1:0] fp_word_t;
	typedef logic [EXP_WIDTH-1:0] exp_t;
	typedef logic [EXT_WIDTH-1:0] ext_man_t;

	// Carried alongside the align stage
	typedef struct packed {
		logic sign_a;
		logic sign_b;
		exp_t exp_max;
	} side_t;

	// Special operand decision
	typedef struct packed {
		logic special;
		fp_word_t word;
	} special_t;

endpackage

// ==== hdl/fp_pipe_delay.sv ====
`timescale 1ns/1ps

module fp_pipe_delay #(
	parameter type payload_t = logic,
	parameter int DEPTH = 1
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	// One valid bit and one payload per stage
	logic [DEPTH-1:0] valid_q;
	payload_t data_q [DEPTH];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			for (int i = 0; i < DEPTH; i++) begin
				data_q[i] <= '0;
			end
		end else begin
			valid_q[0] <= in_valid;
			data_q[0] <= in_data;
			// Shift toward the tail
			for (int i = 1; i < DEPTH; i++) begin
				valid_q[i] <= valid_q[i-1];
				data_q[i] <= data_q[i-1];
			end
		end
	end

	assign out_valid = valid_q[DEPTH-1];
	assign out_data = data_q[DEPTH-1];

endmodule

// ==== hdl/fp_exp_compare.sv ====
`timescale 1ns/1ps

module fp_exp_compare (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  logic                 op,
	input  fp_add_pkg::fp_word_t a,
	input  fp_add_pkg::fp_word_t b,
	output logic                 out_valid,
	output fp_add_pkg::exp_t     exp_a,
	output fp_add_pkg::exp_t     exp_b,
	output fp_add_pkg::exp_t     exp_diff,
	output fp_add_pkg::ext_man_t man_a,
	output fp_add_pkg::ext_man_t man_b,
	output fp_add_pkg::side_t    side
);

	fp_add_pkg::exp_t raw_exp_a;
	fp_add_pkg::exp_t raw_exp_b;
	fp_add_pkg::exp_t diff;
	fp_add_pkg::exp_t diff_clamped;
	fp_add_pkg::ext_man_t ext_a;
	fp_add_pkg::ext_man_t ext_b;
	fp_add_pkg::side_t side_d;

	////////////////////////////////////////////////////////////////////////////
	// Unpack
	assign raw_exp_a = a[fp_add_pkg::FP_WIDTH-2 -: fp_add_pkg::EXP_WIDTH];
	assign raw_exp_b = b[fp_add_pkg::FP_WIDTH-2 -: fp_add_pkg::EXP_WIDTH];

	// Hidden bit is zero for a zero exponent
	assign ext_a = {1'b0, |raw_exp_a, a[fp_add_pkg::MAN_WIDTH-1:0], 3'b000};
	assign ext_b = {1'b0, |raw_exp_b, b[fp_add_pkg::MAN_WIDTH-1:0], 3'b000};

	// Absolute exponent difference
	assign diff = (raw_exp_a >= raw_exp_b) ? raw_exp_a - raw_exp_b : raw_exp_b - raw_exp_a;

	// Anything past the mantissa width shifts out completely
	assign diff_clamped = (diff > fp_add_pkg::EXT_WIDTH - 1) ?
		fp_add_pkg::exp_t'(fp_add_pkg::EXT_WIDTH - 1) : diff;

	// Subtract flips the sign of b
	assign side_d.sign_a = a[fp_add_pkg::FP_WIDTH-1];
	assign side_d.sign_b = b[fp_add_pkg::FP_WIDTH-1] ^ op;
	assign side_d.exp_max = (raw_exp_a >= raw_exp_b) ? raw_exp_a : raw_exp_b;

	////////////////////////////////////////////////////////////////////////////
	// Stage register
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			exp_a <= '0;
			exp_b <= '0;
			exp_diff <= '0;
			man_a <= '0;
			man_b <= '0;
			side <= '0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				exp_a <= raw_exp_a;
				exp_b <= raw_exp_b;
				exp_diff <= diff_clamped;
				man_a <= ext_a;
				man_b <= ext_b;
				side <= side_d;
			end
		end
	end

endmodule

// ==== hdl/fp_mantissa_align.sv ====
`timescale 1ns/1ps

module fp_mantissa_align (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 valid_in,
	input  fp_add_pkg::exp_t     in_exp_a,
	input  fp_add_pkg::exp_t     in_exp_b,
	input  fp_add_pkg::exp_t     in_exp_diff,
	input  fp_add_pkg::ext_man_t in_man_a,
	input  fp_add_pkg::ext_man_t in_man_b,
	output fp_add_pkg::ext_man_t out_man_a,
	output fp_add_pkg::ext_man_t out_man_b,
	output logic                 valid_out
);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_man_a <= '0;
			out_man_b <= '0;
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
			if (valid_in) begin
				// Equal exponents keep a as the larger
				if (in_exp_a >= in_exp_b) begin
					out_man_a <= in_man_a;
					out_man_b <= in_man_b >> in_exp_diff;
				end else begin
					// b larger so a moves down
					out_man_a <= in_man_a >> in_exp_diff;
					out_man_b <= in_man_b;
				end
			end
		end
	end

endmodule

// ==== hdl/fp_mantissa_sum.sv ====
`timescale 1ns/1ps

module fp_mantissa_sum (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  fp_add_pkg::ext_man_t man_a,
	input  fp_add_pkg::ext_man_t man_b,
	input  fp_add_pkg::side_t    side,
	output logic                 out_valid,
	output fp_add_pkg::ext_man_t sum_man,
	output logic                 sum_sign,
	output fp_add_pkg::exp_t     sum_exp
);

	logic a_ge_b;
	fp_add_pkg::ext_man_t mag;
	logic mag_sign;

	// Aligned mantissas share one scale
	assign a_ge_b = man_a >= man_b;

	////////////////////////////////////////////////////////////////////////////
	// Signed magnitude add
	always_comb begin
		if (side.sign_a == side.sign_b) begin
			// Same sign, magnitudes add, carry bit catches overflow
			mag = man_a + man_b;
			mag_sign = side.sign_a;
		end else if (a_ge_b) begin
			mag = man_a - man_b;
			mag_sign = side.sign_a;
		end else begin
			// b dominates
			mag = man_b - man_a;
			mag_sign = side.sign_b;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage register
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			sum_man <= '0;
			sum_sign <= 1'b0;
			sum_exp <= '0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				sum_man <= mag;
				// Exact cancellation gives +0
				sum_sign <= mag_sign & (|mag);
				sum_exp <= side.exp_max;
			end
		end
	end

endmodule

// ==== hdl/fp_normalize.sv ====
`timescale 1ns/1ps

module fp_normalize (
	input  fp_add_pkg::ext_man_t sum_man,
	input  logic                 sum_sign,
	input  fp_add_pkg::exp_t     sum_exp,
	output fp_add_pkg::fp_word_t norm_word
);

	int lead_pos;
	int shift_amt;
	int exp_new;
	int true_exp;
	fp_add_pkg::ext_man_t norm_man;

	////////////////////////////////////////////////////////////////////////////
	// Leading one position
	always_comb begin
		lead_pos = 0;
		// Highest set bit wins
		for (int i = 0; i < fp_add_pkg::EXT_WIDTH; i++) begin
			if (sum_man[i]) begin
				lead_pos = i;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Shift and exponent adjust
	always_comb begin
		shift_amt = 0;
		if (sum_man[fp_add_pkg::EXT_WIDTH-1]) begin
			// Carry out, one place right
			norm_man = sum_man >> 1;
			exp_new = int'(sum_exp) + 1;
		end else begin
			// Bring the leading one up to the hidden bit
			shift_amt = (fp_add_pkg::EXT_WIDTH - 2) - lead_pos;
			norm_man = sum_man << shift_amt;
			exp_new = int'(sum_exp) - shift_amt;
		end
		// Unbiased exponent
		true_exp = exp_new - fp_add_pkg::EXP_BIAS;
	end

	////////////////////////////////////////////////////////////////////////////
	// Range check and pack
	always_comb begin
		if (sum_man == '0 || true_exp <= -fp_add_pkg::EXP_BIAS) begin
			// Zero or underflow, denormals flush
			norm_word = {sum_sign, {(fp_add_pkg::FP_WIDTH-1){1'b0}}};
		end else if (true_exp >= fp_add_pkg::EXP_MAX - fp_add_pkg::EXP_BIAS) begin
			// Overflow saturates to infinity
			norm_word = {sum_sign, fp_add_pkg::exp_t'(fp_add_pkg::EXP_MAX),
				{fp_add_pkg::MAN_WIDTH{1'b0}}};
		end else begin
			// Guard bits truncated
			norm_word = {sum_sign, fp_add_pkg::exp_t'(true_exp + fp_add_pkg::EXP_BIAS),
				norm_man[fp_add_pkg::EXT_WIDTH-3 -: fp_add_pkg::MAN_WIDTH]};
		end
	end

endmodule

// ==== hdl/fp_add_ctrl.sv ====
`timescale 1ns/1ps

module fp_add_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  logic                 op,
	input  fp_add_pkg::fp_word_t a,
	input  fp_add_pkg::fp_word_t b,
	input  logic                 sum_valid,
	input  fp_add_pkg::fp_word_t norm_word,
	output logic                 out_valid,
	output fp_add_pkg::fp_word_t result
);

	logic sign_a;
	logic sign_b;
	logic max_a;
	logic max_b;
	logic nan_a;
	logic nan_b;
	logic inf_a;
	logic inf_b;
	logic zero_a;
	logic zero_b;
	fp_add_pkg::special_t spec_in;
	fp_add_pkg::special_t spec_out;
	logic spec_valid;

	////////////////////////////////////////////////////////////////////////////
	// Operand classes
	assign sign_a = a[fp_add_pkg::FP_WIDTH-1];
	assign sign_b = b[fp_add_pkg::FP_WIDTH-1] ^ op;
	assign max_a = a[fp_add_pkg::FP_WIDTH-2 -: fp_add_pkg::EXP_WIDTH] == fp_add_pkg::EXP_MAX;
	assign max_b = b[fp_add_pkg::FP_WIDTH-2 -: fp_add_pkg::EXP_WIDTH] == fp_add_pkg::EXP_MAX;
	assign nan_a = max_a && (|a[fp_add_pkg::MAN_WIDTH-1:0]);
	assign nan_b = max_b && (|b[fp_add_pkg::MAN_WIDTH-1:0]);
	assign inf_a = max_a && !(|a[fp_add_pkg::MAN_WIDTH-1:0]);
	assign inf_b = max_b && !(|b[fp_add_pkg::MAN_WIDTH-1:0]);
	// Zero and denormal look alike here
	assign zero_a = a[fp_add_pkg::FP_WIDTH-2 -: fp_add_pkg::EXP_WIDTH] == '0;
	assign zero_b = b[fp_add_pkg::FP_WIDTH-2 -: fp_add_pkg::EXP_WIDTH] == '0;

	// Special rules in priority order
	always_comb begin
		spec_in.special = 1'b1;
		if (nan_a || nan_b || (inf_a && inf_b && sign_a != sign_b)) begin
			spec_in.word = fp_add_pkg::QNAN_WORD;
		end else if (inf_a) begin
			spec_in.word = {sign_a, a[fp_add_pkg::FP_WIDTH-2:0]};
		end else if (inf_b) begin
			spec_in.word = {sign_b, b[fp_add_pkg::FP_WIDTH-2:0]};
		end else if (zero_a && zero_b) begin
			// Negative zero only from two negatives
			spec_in.word = {sign_a & sign_b, {(fp_add_pkg::FP_WIDTH-1){1'b0}}};
		end else if (zero_a) begin
			spec_in.word = {sign_b, b[fp_add_pkg::FP_WIDTH-2:0]};
		end else if (zero_b) begin
			spec_in.word = {sign_a, a[fp_add_pkg::FP_WIDTH-2:0]};
		end else begin
			spec_in.special = 1'b0;
			spec_in.word = '0;
		end
	end

	// Lines up with sum_valid
	fp_pipe_delay #(
		.payload_t(fp_add_pkg::special_t),
		.DEPTH(3)
	) u_special_delay (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(spec_in),
		.out_valid(spec_valid),
		.out_data(spec_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output register
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			result <= '0;
		end else begin
			out_valid <= sum_valid;
			if (sum_valid) begin
				result <= (spec_valid && spec_out.special) ? spec_out.word : norm_word;
			end
		end
	end

endmodule

// ==== hdl/fp_add_top.sv ====
`timescale 1ns/1ps

module fp_add_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  logic                 op,
	input  fp_add_pkg::fp_word_t a,
	input  fp_add_pkg::fp_word_t b,
	output logic                 out_valid,
	output fp_add_pkg::fp_word_t result
);

	// Stage 1 outputs
	logic cmp_valid;
	fp_add_pkg::exp_t exp_a;
	fp_add_pkg::exp_t exp_b;
	fp_add_pkg::exp_t exp_diff;
	fp_add_pkg::ext_man_t man_a;
	fp_add_pkg::ext_man_t man_b;
	fp_add_pkg::side_t side;

	// Stage 2 outputs
	logic align_valid;
	fp_add_pkg::ext_man_t align_man_a;
	fp_add_pkg::ext_man_t align_man_b;
	logic side_valid;
	fp_add_pkg::side_t side_d;

	// Stage 3 outputs
	logic sum_valid;
	fp_add_pkg::ext_man_t sum_man;
	logic sum_sign;
	fp_add_pkg::exp_t sum_exp;
	fp_add_pkg::fp_word_t norm_word;

	////////////////////////////////////////////////////////////////////////////
	// Data path
	fp_exp_compare u_exp_compare (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.op(op),
		.a(a),
		.b(b),
		.out_valid(cmp_valid),
		.exp_a(exp_a),
		.exp_b(exp_b),
		.exp_diff(exp_diff),
		.man_a(man_a),
		.man_b(man_b),
		.side(side)
	);

	fp_mantissa_align u_mantissa_align (
		.clk(clk),
		.reset(reset),
		.valid_in(cmp_valid),
		.in_exp_a(exp_a),
		.in_exp_b(exp_b),
		.in_exp_diff(exp_diff),
		.in_man_a(man_a),
		.in_man_b(man_b),
		.out_man_a(align_man_a),
		.out_man_b(align_man_b),
		.valid_out(align_valid)
	);

	// Signs and exponent ride past the align stage
	fp_pipe_delay #(
		.payload_t(fp_add_pkg::side_t),
		.DEPTH(1)
	) u_side_delay (
		.clk(clk),
		.reset(reset),
		.in_valid(cmp_valid),
		.in_data(side),
		.out_valid(side_valid),
		.out_data(side_d)
	);

	fp_mantissa_sum u_mantissa_sum (
		.clk(clk),
		.reset(reset),
		.in_valid(align_valid & side_valid),
		.man_a(align_man_a),
		.man_b(align_man_b),
		.side(side_d),
		.out_valid(sum_valid),
		.sum_man(sum_man),
		.sum_sign(sum_sign),
		.sum_exp(sum_exp)
	);

	fp_normalize u_normalize (
		.sum_man(sum_man),
		.sum_sign(sum_sign),
		.sum_exp(sum_exp),
		.norm_word(norm_word)
	);

	////////////////////////////////////////////////////////////////////////////
	// Special cases and output register
	fp_add_ctrl u_add_ctrl (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.op(op),
		.a(a),
		.b(b),
		.sum_valid(sum_valid),
		.norm_word(norm_word),
		.out_valid(out_valid),
		.result(result)
	);

endmodule

// ==== test/fp_add_props.sv ====
`timescale 1ns/1ps

module fp_add_props (
	input logic                 clk,
	input logic                 reset,
	input logic                 in_valid,
	input logic                 out_valid,
	input fp_add_pkg::fp_word_t result
);

	int fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// Fixed four cycle latency, both directions
	issue_to_out: assert property (@(posedge clk) disable iff (reset)
		$past(in_valid, 4) |-> out_valid)
	else begin
		fail_count++;
		$error("out_valid missing four cycles after in_valid");
	end

	out_from_issue: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(in_valid, 4))
	else begin
		fail_count++;
		$error("out_valid without in_valid four cycles earlier");
	end

	// Quiet under reset and on release
	reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
	else begin
		fail_count++;
		$error("out_valid high after a reset cycle");
	end

	release_quiet: assert property (@(posedge clk) $fell(reset) |=> !out_valid)
	else begin
		fail_count++;
		$error("out_valid high in the cycle after reset release");
	end

	////////////////////////////////////////////////////////////////////////////
	// Every NaN leaves in canonical form
	nan_form: assert property (@(posedge clk) disable iff (reset)
		(out_valid && result[fp_add_pkg::FP_WIDTH-2 -: fp_add_pkg::EXP_WIDTH] == '1
			&& result[fp_add_pkg::MAN_WIDTH-1:0] != '0)
		|-> result == fp_add_pkg::QNAN_WORD)
	else begin
		fail_count++;
		$error("NaN result %h is not the canonical quiet NaN", result);
	end

endmodule

bind fp_add_top fp_add_props u_props (
	.clk(clk),
	.reset(reset),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.result(result)
);

// ==== test/fp_add_tb.sv ====
`timescale 1ns/1ps

module fp_add_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_TIMEOUT = 20;
	localparam int DRAIN_TIMEOUT = 60;
	localparam int QUIET_CYCLES = 6;
	localparam string GOLDEN_PATH = "test/fp_add_golden.txt";

	// DUT ports
	logic clk;
	logic reset;
	logic in_valid;
	logic op;
	fp_add_pkg::fp_word_t a;
	fp_add_pkg::fp_word_t b;
	logic out_valid;
	fp_add_pkg::fp_word_t result;

	// Expected results in issue order
	fp_add_pkg::fp_word_t expected_q[$];
	int seed;
	int errors;
	int in_count;
	int out_count;
	int checked;
	int prop_fails;

	fp_add_top u_fp_add_top (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.op(op),
		.a(a),
		.b(b),
		.out_valid(out_valid),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic check_result(input fp_add_pkg::fp_word_t actual);
		fp_add_pkg::fp_word_t expected;
		if (expected_q.size() == 0) begin
			$display("Result %h at %0t arrived with no operation in flight", actual, $time);
			errors++;
		end else begin
			expected = expected_q.pop_front();
			checked++;
			if (actual !== expected) begin
				$display("MISMATCH at %0t: expected %h, got %h", $time, expected, actual);
				errors++;
			end
		end
	endtask

	task automatic check_count(input int outputs, input int inputs);
		if (outputs != inputs) begin
			$display("MISMATCH at %0t: %0d outputs for %0d inputs", $time, outputs, inputs);
			errors++;
		end
	endtask

	// Outputs change on the rising edge, look at them on the falling one
	always @(negedge clk) begin
		if (out_valid === 1'b1) begin
			out_count++;
			check_result(result);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus from the golden file
	initial begin
		int fd;
		int gap;
		int wait_cycles;
		string line;
		logic [3:0] v_op;
		fp_add_pkg::fp_word_t v_a;
		fp_add_pkg::fp_word_t v_b;
		fp_add_pkg::fp_word_t v_exp;

		seed = 32'h08755b0d;
		errors = 0;
		in_count = 0;
		out_count = 0;
		checked = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		op = 1'b0;
		a = '0;
		b = '0;

		// Two rising edges under reset
		repeat (2) @(negedge clk);
		reset = 1'b0;

		// DUT settles to a known idle output after release
		wait_cycles = 0;
		while (out_valid !== 1'b0 && wait_cycles < RESET_TIMEOUT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (out_valid !== 1'b0) begin
			$display("Timed out waiting for out_valid to settle low after reset");
			errors++;
		end

		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0) begin
			$display("Could not open the golden file %s", GOLDEN_PATH);
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Skip comment and blank lines
				if (line.len() > 1 && line.getc(0) != "/") begin
					if ($sscanf(line, "%h %h %h %h", v_op, v_a, v_b, v_exp) == 4) begin
						in_valid = 1'b1;
						op = v_op[0];
						a = v_a;
						b = v_b;
						expected_q.push_back(v_exp);
						in_count++;
						@(negedge clk);
						in_valid = 1'b0;
						// Most draws stream back to back
						gap = $random(seed) & 7;
						if (gap > 3) begin
							gap = 0;
						end
						repeat (gap) @(negedge clk);
					end
				end
			end
			$fclose(fd);
		end
		in_valid = 1'b0;

		////////////////////////////////////////////////////////////////////////
		// Drain
		wait_cycles = 0;
		while (expected_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (expected_q.size() != 0) begin
			$display("Timed out with %0d results still missing", expected_q.size());
			errors++;
		end
		// Stray outputs would show up here
		repeat (QUIET_CYCLES) @(negedge clk);
		check_count(out_count, in_count);

		prop_fails = u_fp_add_top.u_props.fail_count;
		errors += prop_fails;
		$display("Checked %0d results for %0d inputs, %0d assertion failures, %0d errors",
			checked, in_count, prop_fails, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== test/fp_add_golden.txt ====
// op a b expected, all hex
// op 0 adds, op 1 subtracts
0 3f800000 3f800000 40000000
0 3f800000 40000000 40400000
1 40400000 3f800000 40000000
0 3f800000 3fc00000 40200000
0 c0000000 c0400000 c0a00000
1 3f800000 40800000 c0400000
0 4e800000 3f800000 4e800000
1 3f800000 4e800000 ce800000
0 3f800000 33800000 3f800000
1 3f800000 33800000 3f7fffff
1 3f800000 3f7fffff 33800000
1 3fc00000 3fa00000 3e800000
1 3f800000 3f800000 00000000
0 bf800000 3f800000 00000000
0 7fc00000 3f800000 7fc00000
0 ff800001 00000000 7fc00000
1 7f800000 7f800000 7fc00000
0 7f800000 7f800000 7f800000
0 3f800000 ff800000 ff800000
1 3f800000 ff800000 7f800000
0 00000000 00000000 00000000
0 80000000 80000000 80000000
1 80000000 00000000 80000000
0 80000000 00000000 00000000
0 00000001 80000000 00000000
1 00000000 3f800000 bf800000
0 40400000 00000005 40400000
0 7f7fffff 7f7fffff 7f800000
0 ff7fffff ff7fffff ff800000
1 00800000 00c00000 80000000
1 00c00000 00800000 00000000
0 00800000 00800000 01000000

// ==== compile.f ====
hdl/fp_add_pkg.sv
hdl/fp_pipe_delay.sv
hdl/fp_exp_compare.sv
hdl/fp_mantissa_align.sv
hdl/fp_mantissa_sum.sv
hdl/fp_normalize.sv
hdl/fp_add_ctrl.sv
hdl/fp_add_top.sv
test/fp_add_props.sv
test/fp_add_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fp_add_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000
PASS_MSG  = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
